//--- qpi_config.svh
`ifndef QPI_CONFIG_SVH
`define QPI_CONFIG_SVH

// ==============================
// Configuration register map
// ==============================

// Byte addresses, compared against the dword index from the header times four.
`define ADDR_AFU_DSM_BASEL     14'h1A00
`define ADDR_AFU_DSM_BASEH     14'h1A04
`define ADDR_AFU_CNTXT_BASEL   14'h1A08
`define ADDR_AFU_CNTXT_BASEH   14'h1A0C
`define ADDR_AFU_EN            14'h1A10
`define ADDR_READ_FRAME_BASEL  14'h1A14
`define ADDR_READ_FRAME_BASEH  14'h1A18
`define ADDR_WRITE_FRAME_BASEL 14'h1A1C
`define ADDR_WRITE_FRAME_BASEH 14'h1A20

// ==============================
// Unit constants
// ==============================

`define QPI_AFU_ID 64'h11F3_A8C2_5C0F_0001

// Lines copied per run.
`define QPI_FRAME_LINES 16

// Response buffer entries, which also bounds the reads in flight.
`define QPI_COPY_DEPTH 8

`endif

//--- qpi_pkg.sv
package qpi_pkg;

  // ==============================
  // Widths with a meaning
  // ==============================

  typedef logic [57:0]  line_addr_t;  // Byte address without the 6 offset bits.
  typedef logic [63:0]  byte_addr_t;
  typedef logic [511:0] line_data_t;
  typedef logic [11:0]  tag_t;

  // ==============================
  // Link channels
  // ==============================

  typedef struct packed {
    logic        cfgvalid;
    logic        rdvalid;
    logic [17:0] header;  // Register index or read tag in bits 11..0.
    line_data_t  data;
  } rx_c0_t;

  typedef struct packed {
    logic wrvalid;
    tag_t tag;
  } rx_c1_t;

  typedef struct packed {
    logic       rdvalid;
    tag_t       tag;
    line_addr_t addr;
  } tx_c0_t;

  typedef struct packed {
    logic       wrvalid;
    tag_t       tag;
    line_addr_t addr;
    line_data_t data;
  } tx_c1_t;

  // Register file as seen by the rest of the unit.
  typedef struct packed {
    byte_addr_t afu_dsm_base;
    logic       afu_dsm_base_valid;
    byte_addr_t afu_cntxt_base;
    logic       afu_cntxt_base_valid;
    logic       afu_en;
    byte_addr_t afu_read_frame;
    byte_addr_t afu_write_frame;
  } afu_csr_t;

  // ==============================
  // State machines
  // ==============================

  typedef enum logic [1:0] {
    COPY_IDLE,
    COPY_RUN,
    COPY_DRAIN
  } copy_state_t;

  typedef enum logic [2:0] {
    CTRL_IDLE,
    CTRL_ID_WRITE,
    CTRL_COPY,
    CTRL_STATUS_WRITE,
    CTRL_DONE
  } ctrl_state_t;

endpackage

//--- qpi_csr.sv
`timescale 1ns/1ps
`include "qpi_config.svh"

module qpi_csr
  import qpi_pkg::*;
(
  input  logic     clk,
  input  logic     resetb,
  input  rx_c0_t   rx0,
  output afu_csr_t csr
);

  logic [13:0] cfg_addr;
  byte_addr_t  dsm_base;
  byte_addr_t  cntxt_base;
  byte_addr_t  read_frame;
  byte_addr_t  write_frame;
  logic        dsm_base_valid;
  logic        cntxt_base_valid;
  logic        afu_en;

  assign cfg_addr = {rx0.header[11:0], 2'b00};  // Dword index to byte address.

  // ==============================
  // Base registers
  // ==============================

  always_ff @(posedge clk) begin
    if (rx0.cfgvalid) begin
      case (cfg_addr)
        `ADDR_AFU_DSM_BASEL:     dsm_base[31:0] <= rx0.data[31:0];
        `ADDR_AFU_DSM_BASEH:     dsm_base[63:32] <= rx0.data[31:0];
        `ADDR_AFU_CNTXT_BASEL:   cntxt_base[31:0] <= rx0.data[31:0];
        `ADDR_AFU_CNTXT_BASEH:   cntxt_base[63:32] <= rx0.data[31:0];
        `ADDR_READ_FRAME_BASEL:  read_frame[31:0] <= rx0.data[31:0];
        `ADDR_READ_FRAME_BASEH:  read_frame[63:32] <= rx0.data[31:0];
        `ADDR_WRITE_FRAME_BASEL: write_frame[31:0] <= rx0.data[31:0];
        `ADDR_WRITE_FRAME_BASEH: write_frame[63:32] <= rx0.data[31:0];
        default: ;
      endcase
    end
  end

  // ==============================
  // Valid bits and enable
  // ==============================

  always_ff @(posedge clk) begin
    if (!resetb) begin
      dsm_base_valid   <= 1'b0;
      cntxt_base_valid <= 1'b0;
      afu_en           <= 1'b0;
    end else if (rx0.cfgvalid) begin
      case (cfg_addr)
        `ADDR_AFU_DSM_BASEL:   dsm_base_valid <= 1'b1;  // Low half marks the base usable.
        `ADDR_AFU_CNTXT_BASEL: cntxt_base_valid <= 1'b1;
        `ADDR_AFU_EN:          afu_en <= rx0.data[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    csr.afu_dsm_base         = dsm_base;
    csr.afu_dsm_base_valid   = dsm_base_valid;
    csr.afu_cntxt_base       = cntxt_base;
    csr.afu_cntxt_base_valid = cntxt_base_valid;
    csr.afu_en               = afu_en;
    csr.afu_read_frame       = read_frame;
    csr.afu_write_frame      = write_frame;
  end

endmodule

//--- qpi_frame_copy.sv
`timescale 1ns/1ps
`include "qpi_config.svh"

module qpi_frame_copy
  import qpi_pkg::*;
(
  input  logic       clk,
  input  logic       resetb,
  input  logic       start,
  input  logic       abort,
  input  byte_addr_t read_base,
  input  byte_addr_t write_base,
  input  rx_c0_t     rx0,
  input  rx_c1_t     rx1,
  input  logic       tx0_almostfull,
  output tx_c0_t     tx0,
  output tx_c1_t     wr_req,
  input  logic       wr_take,
  output logic       done
);

  localparam int IDX_W = $clog2(`QPI_FRAME_LINES + 1);
  localparam int CNT_W = $clog2(`QPI_COPY_DEPTH + 1);
  localparam int PTR_W = $clog2(`QPI_COPY_DEPTH);

  copy_state_t      state;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_cnt;
  logic [CNT_W-1:0] in_use;  // Reads in flight plus lines held in the FIFO.
  logic [CNT_W-1:0] fifo_cnt;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  tag_t             fifo_tag [`QPI_COPY_DEPTH];
  line_data_t       fifo_data [`QPI_COPY_DEPTH];
  logic             rd_fire;
  logic             push;
  logic             resp_hit;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`QPI_COPY_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // A read goes out only while a buffer slot is still unclaimed.
  assign rd_fire  = (state == COPY_RUN) && !tx0_almostfull &&
                    (in_use < CNT_W'(`QPI_COPY_DEPTH));
  assign push     = rx0.rdvalid && (state != COPY_IDLE);
  assign resp_hit = rx1.wrvalid && (rx1.tag < tag_t'(`QPI_FRAME_LINES)) &&
                    (state != COPY_IDLE);
  assign done     = (state == COPY_DRAIN) && (wr_cnt == IDX_W'(`QPI_FRAME_LINES));

  // ==============================
  // Read requests
  // ==============================

  always_comb begin
    tx0.rdvalid = rd_fire;
    tx0.tag     = tag_t'(rd_idx);  // The line index returns as the tag.
    tx0.addr    = read_base[63:6] + line_addr_t'(rd_idx);
  end

  // ==============================
  // Response FIFO and write offer
  // ==============================

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_tag[wr_ptr]  <= rx0.header[11:0];
      fifo_data[wr_ptr] <= rx0.data;
    end
  end

  always_comb begin
    wr_req.wrvalid = (fifo_cnt != '0);
    wr_req.tag     = fifo_tag[rd_ptr];
    wr_req.addr    = write_base[63:6] + line_addr_t'(fifo_tag[rd_ptr]);
    wr_req.data    = fifo_data[rd_ptr];
  end

  // ==============================
  // Control
  // ==============================

  always_ff @(posedge clk) begin
    if (!resetb || abort) begin
      state    <= COPY_IDLE;
      rd_idx   <= '0;
      wr_cnt   <= '0;
      in_use   <= '0;
      fifo_cnt <= '0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
    end else begin
      case (state)
        COPY_IDLE: begin
          if (start) begin
            state <= COPY_RUN;
          end
        end
        COPY_RUN: begin
          if (rd_fire && (rd_idx == IDX_W'(`QPI_FRAME_LINES - 1))) begin
            state <= COPY_DRAIN;  // Last read is out.
          end
        end
        default: ;
      endcase
      if (rd_fire) begin
        rd_idx <= rd_idx + 1'b1;
      end
      if (resp_hit) begin
        wr_cnt <= wr_cnt + 1'b1;
      end
      in_use   <= in_use + CNT_W'(rd_fire) - CNT_W'(wr_take);  // Take returns the credit.
      fifo_cnt <= fifo_cnt + CNT_W'(push) - CNT_W'(wr_take);
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (wr_take) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

endmodule

//--- qpi_afu_ctrl.sv
`timescale 1ns/1ps
`include "qpi_config.svh"

module qpi_afu_ctrl
  import qpi_pkg::*;
(
  input  logic     clk,
  input  logic     resetb,
  input  afu_csr_t csr,
  input  rx_c1_t   rx1,
  input  logic     tx1_almostfull,
  output tx_c1_t   tx1,
  input  tx_c1_t   copy_req,
  output logic     copy_take,
  output logic     copy_start,
  output logic     copy_abort,
  input  logic     copy_done
);

  localparam tag_t ID_TAG     = 12'hF00;
  localparam tag_t STATUS_TAG = 12'hF01;

  ctrl_state_t state;
  logic        en_q;
  logic        en_rise;
  logic        id_fire;
  logic        status_fire;
  logic        status_sent;
  logic        id_acked;
  logic        status_acked;
  line_addr_t  dsm_line;
  line_data_t  id_data;
  line_data_t  status_data;

  assign en_rise     = csr.afu_en && !en_q;
  assign copy_abort  = !csr.afu_en && en_q;  // Falling enable.
  assign dsm_line    = csr.afu_dsm_base[63:6];
  assign id_data     = line_data_t'(`QPI_AFU_ID);
  // Completion record: done flag in bit 0, line count in bits 47..32.
  assign status_data = line_data_t'({16'(`QPI_FRAME_LINES), 31'd0, 1'b1});

  assign id_fire     = (state == CTRL_ID_WRITE) && !tx1_almostfull;
  assign status_fire = (state == CTRL_STATUS_WRITE) && !status_sent && !tx1_almostfull;
  assign copy_start  = id_fire;
  assign copy_take   = (state == CTRL_COPY) && copy_req.wrvalid && !tx1_almostfull;

  // ==============================
  // Write channel mux
  // ==============================

  always_comb begin
    tx1 = '0;
    case (state)
      CTRL_ID_WRITE: begin
        tx1.wrvalid = id_fire;
        tx1.tag     = ID_TAG;
        tx1.addr    = dsm_line;
        tx1.data    = id_data;
      end
      CTRL_COPY: begin
        tx1         = copy_req;
        tx1.wrvalid = copy_take;
      end
      CTRL_STATUS_WRITE: begin
        tx1.wrvalid = status_fire;
        tx1.tag     = STATUS_TAG;
        tx1.addr    = dsm_line + line_addr_t'(1);
        tx1.data    = status_data;
      end
      default: tx1 = '0;
    endcase
  end

  // ==============================
  // Sequencer
  // ==============================

  always_ff @(posedge clk) begin
    if (!resetb) begin
      state        <= CTRL_IDLE;
      en_q         <= 1'b0;
      status_sent  <= 1'b0;
      id_acked     <= 1'b0;
      status_acked <= 1'b0;
    end else begin
      en_q <= csr.afu_en;
      if (rx1.wrvalid && (rx1.tag == ID_TAG)) begin
        id_acked <= 1'b1;
      end
      if (rx1.wrvalid && (rx1.tag == STATUS_TAG)) begin
        status_acked <= 1'b1;
      end
      if (status_fire) begin
        status_sent <= 1'b1;
      end
      case (state)
        CTRL_IDLE: begin
          if (en_rise && csr.afu_dsm_base_valid) begin
            state        <= CTRL_ID_WRITE;
            status_sent  <= 1'b0;
            id_acked     <= 1'b0;
            status_acked <= 1'b0;
          end
        end
        CTRL_ID_WRITE: begin
          if (id_fire) begin
            state <= CTRL_COPY;
          end
        end
        CTRL_COPY: begin
          if (copy_done) begin
            state <= CTRL_STATUS_WRITE;  // Every frame write has its response.
          end
        end
        CTRL_STATUS_WRITE: begin
          if (status_acked && id_acked) begin
            state <= CTRL_DONE;
          end
        end
        default: ;
      endcase
      if (!csr.afu_en) begin
        state <= CTRL_IDLE;
      end
    end
  end

endmodule

//--- qpi_afu.sv
`timescale 1ns/1ps

module qpi_afu
  import qpi_pkg::*;
(
  input  logic   clk,
  input  logic   resetb,
  input  rx_c0_t rx0,
  input  rx_c1_t rx1,
  input  logic   tx0_almostfull,
  input  logic   tx1_almostfull,
  output tx_c0_t tx0,
  output tx_c1_t tx1
);

  afu_csr_t csr;
  tx_c1_t   copy_req;
  logic     copy_take;
  logic     copy_start;
  logic     copy_abort;
  logic     copy_done;

  qpi_csr qpi_csr_inst (
    .clk    (clk),
    .resetb (resetb),
    .rx0    (rx0),
    .csr    (csr)
  );

  qpi_frame_copy qpi_frame_copy_inst (
    .clk            (clk),
    .resetb         (resetb),
    .start          (copy_start),
    .abort          (copy_abort),
    .read_base      (csr.afu_read_frame),
    .write_base     (csr.afu_write_frame),
    .rx0            (rx0),
    .rx1            (rx1),
    .tx0_almostfull (tx0_almostfull),
    .tx0            (tx0),
    .wr_req         (copy_req),
    .wr_take        (copy_take),
    .done           (copy_done)
  );

  qpi_afu_ctrl qpi_afu_ctrl_inst (
    .clk            (clk),
    .resetb         (resetb),
    .csr            (csr),
    .rx1            (rx1),
    .tx1_almostfull (tx1_almostfull),
    .tx1            (tx1),
    .copy_req       (copy_req),
    .copy_take      (copy_take),
    .copy_start     (copy_start),
    .copy_abort     (copy_abort),
    .copy_done      (copy_done)
  );

endmodule

//--- tb_qpi_afu.sv
`timescale 1ns/1ps
`include "qpi_config.svh"

module tb_qpi_afu
  import qpi_pkg::*;
;

  localparam int CLK_PERIOD      = 8;
  localparam int RUNS            = 2;
  localparam int WATCHDOG_CYCLES = RUNS * (`QPI_FRAME_LINES * 40 + 500);
  localparam tag_t ID_TAG        = 12'hF00;
  localparam tag_t STATUS_TAG    = 12'hF01;

  typedef struct packed {
    logic [31:0] due;  // Cycle from which the response may be returned.
    tag_t        tag;
    line_addr_t  addr;
  } pending_t;

  typedef struct packed {
    logic [11:0] idx;
    logic [31:0] data;
  } cfg_write_t;

  logic   clk;
  logic   resetb;
  rx_c0_t rx0;
  rx_c1_t rx1;
  logic   tx0_almostfull;
  logic   tx1_almostfull;
  tx_c0_t tx0;
  tx_c1_t tx1;

  line_data_t mem [line_addr_t];  // Sparse host memory.
  line_data_t src [`QPI_FRAME_LINES];
  pending_t   rd_q [$];
  pending_t   wr_q [$];
  cfg_write_t cfg_q [$];

  byte_addr_t dsm_base;
  byte_addr_t rd_base;
  byte_addr_t wr_base;
  line_addr_t dsm_line;
  line_addr_t rd_line;
  line_addr_t wr_line;
  logic [`QPI_FRAME_LINES-1:0] read_seen;
  logic       enabled;
  logic       id_seen;
  logic       status_seen;
  logic       status_acked;
  int         frame_resp;
  int         cycle;

  qpi_afu qpi_afu_inst (
    .clk            (clk),
    .resetb         (resetb),
    .rx0            (rx0),
    .rx1            (rx1),
    .tx0_almostfull (tx0_almostfull),
    .tx1_almostfull (tx1_almostfull),
    .tx0            (tx0),
    .tx1            (tx1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==============================
  // Reporting
  // ==============================

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input line_data_t got,
                                 input line_data_t exp);
    abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("Timeout after %0d cycles without finishing both runs.",
                        WATCHDOG_CYCLES));
  end

  // ==============================
  // Host model
  // ==============================

  function automatic byte_addr_t random_base();
    return {$urandom() | 32'h1, $urandom() & 32'hFFFF_FFC0};  // Line aligned.
  endfunction

  function automatic line_data_t random_data();
    line_data_t d;
    for (int w = 0; w < 16; w++) begin
      d[32*w +: 32] = $urandom();
    end
    return d;
  endfunction

  task automatic queue_cfg(input logic [13:0] addr, input logic [31:0] data);
    cfg_write_t cw;
    cw.idx  = addr[13:2];
    cw.data = data;
    cfg_q.push_back(cw);
  endtask

  // Requests are sampled at the rising edge.
  task automatic check_requests();
    line_data_t exp_status;
    pending_t   p;
    int         idx;
    exp_status        = '0;
    exp_status[0]     = 1'b1;
    exp_status[47:32] = 16'(`QPI_FRAME_LINES);
    if (!enabled) begin
      assert (!tx0.rdvalid && !tx1.wrvalid)
        else abort_run("Request issued while the unit was disabled.");
    end
    if (tx0.rdvalid) begin
      assert (!tx0_almostfull) else abort_run("Read issued while tx0_almostfull was high.");
      assert (tx0.tag < tag_t'(`QPI_FRAME_LINES)) else abort_run("Read tag outside the frame.");
      idx = int'(tx0.tag);
      assert (tx0.addr == rd_line + line_addr_t'(idx))
        else report_mismatch("tx0.addr", tx0.addr, rd_line + line_addr_t'(idx));
      assert (!read_seen[idx]) else abort_run("Frame line read twice in one run.");
      read_seen[idx] = 1'b1;
      p.due  = cycle + 1 + $urandom_range(11);
      p.tag  = tx0.tag;
      p.addr = tx0.addr;
      rd_q.push_back(p);
    end
    if (tx1.wrvalid) begin
      assert (!tx1_almostfull) else abort_run("Write issued while tx1_almostfull was high.");
      if (!id_seen) begin
        assert (tx1.addr == dsm_line) else report_mismatch("tx1.addr", tx1.addr, dsm_line);
        assert (tx1.tag == ID_TAG) else report_mismatch("tx1.tag", tx1.tag, ID_TAG);
        assert (tx1.data == line_data_t'(`QPI_AFU_ID))
          else report_mismatch("tx1.data", tx1.data, line_data_t'(`QPI_AFU_ID));
        id_seen = 1'b1;
      end else if (tx1.addr == dsm_line + line_addr_t'(1)) begin
        assert (!status_seen) else abort_run("Completion record written twice.");
        assert (frame_resp == `QPI_FRAME_LINES)
          else abort_run("Completion record written before all frame write responses.");
        assert (tx1.tag == STATUS_TAG) else report_mismatch("tx1.tag", tx1.tag, STATUS_TAG);
        assert (tx1.data == exp_status) else report_mismatch("tx1.data", tx1.data, exp_status);
        status_seen = 1'b1;
      end else begin
        assert (!status_seen) else abort_run("Frame write after the completion record.");
        assert (tx1.addr >= wr_line && tx1.addr < wr_line + line_addr_t'(`QPI_FRAME_LINES))
          else abort_run("Write outside the frame and status lines.");
        assert (tx1.tag == tag_t'(tx1.addr - wr_line))
          else report_mismatch("tx1.tag", tx1.tag, tx1.addr - wr_line);
      end
      mem[tx1.addr] = tx1.data;
      p.due  = cycle + 1 + $urandom_range(7);
      p.tag  = tx1.tag;
      p.addr = tx1.addr;
      wr_q.push_back(p);
    end
  endtask

  // Drives the link inputs at the falling edge.
  task automatic drive_host();
    int         ready [$];
    int         i;
    int         k;
    cfg_write_t cw;
    pending_t   p;
    rx0            = '0;
    rx1            = '0;
    tx0_almostfull = ($urandom_range(3) == 0);
    tx1_almostfull = ($urandom_range(3) == 0);
    if (cfg_q.size() > 0) begin
      cw           = cfg_q.pop_front();
      rx0.cfgvalid = 1'b1;
      rx0.header   = 18'(cw.idx);
      rx0.data     = line_data_t'(cw.data);
      if ({cw.idx, 2'b00} == `ADDR_AFU_EN) begin
        enabled = cw.data[0];
      end
    end else begin
      for (i = 0; i < rd_q.size(); i++) begin
        if (rd_q[i].due <= cycle) ready.push_back(i);
      end
      if (ready.size() > 0) begin
        k = ready[$urandom_range(ready.size() - 1)];  // Out of order return.
        p = rd_q[k];
        rd_q.delete(k);
        rx0.rdvalid = 1'b1;
        rx0.header  = 18'(p.tag);
        rx0.data    = mem[p.addr];
      end
    end
    for (i = 0; i < wr_q.size(); i++) begin
      if (wr_q[i].due <= cycle) begin
        p = wr_q[i];
        wr_q.delete(i);
        rx1.wrvalid = 1'b1;
        rx1.tag     = p.tag;
        if (p.tag < tag_t'(`QPI_FRAME_LINES)) frame_resp++;
        if (p.tag == STATUS_TAG) status_acked = 1'b1;
        break;
      end
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    cycle++;
    if (resetb) check_requests();
    @(negedge clk);
    drive_host();
  endtask

  // ==============================
  // Runs
  // ==============================

  task automatic run_copy();
    int i;
    dsm_base = random_base();
    rd_base  = random_base();
    wr_base  = random_base();
    dsm_line = dsm_base[63:6];
    rd_line  = rd_base[63:6];
    wr_line  = wr_base[63:6];
    for (i = 0; i < `QPI_FRAME_LINES; i++) begin
      src[i] = random_data();
      mem[rd_line + line_addr_t'(i)] = src[i];
    end
    read_seen    = '0;
    frame_resp   = 0;
    id_seen      = 1'b0;
    status_seen  = 1'b0;
    status_acked = 1'b0;
    queue_cfg(`ADDR_AFU_DSM_BASEL, dsm_base[31:0]);
    queue_cfg(`ADDR_AFU_DSM_BASEH, dsm_base[63:32]);
    queue_cfg(`ADDR_AFU_CNTXT_BASEL, $urandom() & 32'hFFFF_FFC0);
    queue_cfg(`ADDR_AFU_CNTXT_BASEH, $urandom());
    queue_cfg(`ADDR_READ_FRAME_BASEL, rd_base[31:0]);
    queue_cfg(`ADDR_READ_FRAME_BASEH, rd_base[63:32]);
    queue_cfg(`ADDR_WRITE_FRAME_BASEL, wr_base[31:0]);
    queue_cfg(`ADDR_WRITE_FRAME_BASEH, wr_base[63:32]);
    queue_cfg(`ADDR_AFU_EN, 32'h1);
    while (!status_acked) next_cycle();
    repeat (4) next_cycle();
    for (i = 0; i < `QPI_FRAME_LINES; i++) begin
      assert (mem.exists(wr_line + line_addr_t'(i)))
        else abort_run($sformatf("Write frame line %0d was never written.", i));
      assert (mem[wr_line + line_addr_t'(i)] == src[i])
        else report_mismatch($sformatf("write frame line %0d", i),
                             mem[wr_line + line_addr_t'(i)], src[i]);
    end
    assert (&read_seen) else abort_run("Not every frame line was read.");
    queue_cfg(`ADDR_AFU_EN, 32'h0);
    while (cfg_q.size() > 0) next_cycle();
    repeat (8) next_cycle();  // Disabled unit must stay quiet.
  endtask

  initial begin
    int run;
    void'($urandom(74));
    rx0            = '0;
    rx1            = '0;
    tx0_almostfull = 1'b0;
    tx1_almostfull = 1'b0;
    resetb         = 1'b0;
    enabled        = 1'b0;
    id_seen        = 1'b0;
    status_seen    = 1'b0;
    status_acked   = 1'b0;
    read_seen      = '0;
    frame_resp     = 0;
    cycle          = 0;
    repeat (5) next_cycle();
    resetb = 1'b1;
    repeat (10) next_cycle();
    for (run = 0; run < RUNS; run++) begin
      run_copy();
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- qpi_afu.f
+incdir+.
qpi_pkg.sv
qpi_csr.sv
qpi_frame_copy.sv
qpi_afu_ctrl.sv
qpi_afu.sv
tb_qpi_afu.sv

//--- Makefile
# Verilator build for the QPI accelerator unit.

VERILATOR  := verilator
TOP        := tb_qpi_afu
RTL_TOP    := qpi_afu
FILELIST   := qpi_afu.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
